// File: logic/axi_bridge_pkg.sv
package axi_bridge_pkg;

    // ******************************
    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = 4;
    localparam int id_w   = 4;

    // source ids carried on arid, awid and wid
    localparam logic [id_w-1:0] inst_id = 4'd0;
    localparam logic [id_w-1:0] data_id = 4'd1;

    // ******************************
    // fixed fields, single beat only
    localparam logic [7:0] axi_len    = 8'd0;
    localparam logic [1:0] burst_incr = 2'b01;
    localparam logic [1:0] axi_lock   = 2'b00;
    localparam logic [3:0] axi_cache  = 4'b0000;
    localparam logic [2:0] axi_prot   = 3'b000;
    localparam logic       axi_wlast  = 1'b1;

    // reads in flight
    localparam int               cnt_w           = 4;
    localparam logic [cnt_w-1:0] max_outstanding = 4'd15;

    // ******************************
    // read request fsm, one-hot
    localparam logic [2:0] st_idle = 3'b001;
    localparam logic [2:0] st_req  = 3'b010;
    localparam logic [2:0] st_ack  = 3'b100;

    // write fsm, one-hot
    localparam logic [4:0] st_w_idle = 5'b00001;
    localparam logic [4:0] st_w_req  = 5'b00010;
    localparam logic [4:0] st_w_addr = 5'b00100;
    localparam logic [4:0] st_w_data = 5'b01000;
    localparam logic [4:0] st_w_resp = 5'b10000;

endpackage

// File: logic/read_request_fsm.sv
`timescale 1ns/1ps

module read_request_fsm (
    input  logic                              aclk,
    input  logic                              aresetn,
    input  logic                              inst_req,
    input  logic                              inst_wr,
    input  logic [1:0]                        inst_size,
    input  logic [axi_bridge_pkg::addr_w-1:0] inst_addr,
    input  logic                              data_req,
    input  logic                              data_wr,
    input  logic [1:0]                        data_size,
    input  logic [axi_bridge_pkg::addr_w-1:0] data_addr,
    input  logic                              arready,
    input  logic                              rd_full,
    input  logic                              wr_busy,
    input  logic [axi_bridge_pkg::addr_w-1:0] wr_addr,
    output logic [axi_bridge_pkg::id_w-1:0]   arid,
    output logic [axi_bridge_pkg::addr_w-1:0] araddr,
    output logic [2:0]                        arsize,
    output logic                              arvalid,
    output logic                              ar_fire,
    output logic                              inst_addr_ok_rd,
    output logic                              data_addr_ok_rd
);
    import axi_bridge_pkg::*;

    logic [2:0]        state;
    logic [2:0]        state_nxt;
    logic              inst_rd;
    logic              data_rd;
    logic [addr_w-1:0] rd_addr_sel;
    logic              rd_go;

    assign inst_rd     = inst_req & ~inst_wr;
    assign data_rd     = data_req & ~data_wr;
    assign rd_addr_sel = data_rd ? data_addr : inst_addr;

    // hold while tracker is full or the write in flight hits the same word
    assign rd_go = (state == st_idle) & (inst_rd | data_rd) & ~rd_full
                 & ~(wr_busy & (rd_addr_sel == wr_addr));

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (rd_go) begin
                    state_nxt = st_req;
                end
            end
            st_req: begin
                if (ar_fire) begin
                    state_nxt = st_ack;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    // data port first
    always_ff @(posedge aclk) begin
        if (rd_go) begin
            arid   <= data_rd ? data_id : inst_id;
            araddr <= rd_addr_sel;
            arsize <= data_rd ? {1'b0, data_size} : {1'b0, inst_size};
        end
    end

    assign arvalid = (state == st_req);
    assign ar_fire = arvalid & arready;

    assign inst_addr_ok_rd = ar_fire & (arid == inst_id);
    assign data_addr_ok_rd = ar_fire & (arid == data_id);

    ar_hold_a: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

// File: logic/read_tracker.sv
`timescale 1ns/1ps

module read_tracker (
    input  logic aclk,
    input  logic aresetn,
    input  logic ar_fire,
    input  logic rvalid,
    output logic rready,
    output logic rd_full
);
    import axi_bridge_pkg::*;

    logic [cnt_w-1:0] rd_cnt;
    logic             r_fire;

    assign r_fire = rvalid & rready;

    // both in one cycle leaves the count alone
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rd_cnt <= '0;
        end else if (ar_fire & ~r_fire) begin
            rd_cnt <= rd_cnt + 1'b1;
        end else if (r_fire & ~ar_fire) begin
            rd_cnt <= rd_cnt - 1'b1;
        end
    end

    assign rready  = (rd_cnt != '0);
    assign rd_full = (rd_cnt == max_outstanding);

    // a beat with nothing outstanding would take the count below zero
    no_underflow_a: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid |-> rd_cnt != '0);

endmodule

// File: logic/read_return_buffer.sv
`timescale 1ns/1ps

module read_return_buffer (
    input  logic                              aclk,
    input  logic                              aresetn,
    input  logic                              rvalid,
    input  logic                              rready,
    input  logic [axi_bridge_pkg::id_w-1:0]   rid,
    input  logic [axi_bridge_pkg::data_w-1:0] rdata,
    output logic [axi_bridge_pkg::data_w-1:0] inst_rdata,
    output logic                              inst_data_ok_rd,
    output logic [axi_bridge_pkg::data_w-1:0] data_rdata,
    output logic                              data_data_ok_rd
);
    import axi_bridge_pkg::*;

    logic r_fire;
    logic ok_q;
    logic src_data_q;

    assign r_fire = rvalid & rready;

    // ******************************
    // one slot per source, low id bit picks it
    always_ff @(posedge aclk) begin
        if (r_fire) begin
            if (rid[0]) begin
                data_rdata <= rdata;
            end else begin
                inst_rdata <= rdata;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (r_fire) begin
            src_data_q <= rid[0];
        end
    end

    // pulse one cycle after the beat
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ok_q <= 1'b0;
        end else begin
            ok_q <= r_fire;
        end
    end

    assign inst_data_ok_rd = ok_q & ~src_data_q;
    assign data_data_ok_rd = ok_q & src_data_q;

    // only the low id bit is decoded
    id_known_a: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid |-> (rid == inst_id || rid == data_id));

endmodule

// File: logic/write_channel_fsm.sv
`timescale 1ns/1ps

module write_channel_fsm (
    input  logic                              aclk,
    input  logic                              aresetn,
    input  logic                              inst_req,
    input  logic                              inst_wr,
    input  logic [1:0]                        inst_size,
    input  logic [axi_bridge_pkg::strb_w-1:0] inst_wstrb,
    input  logic [axi_bridge_pkg::addr_w-1:0] inst_addr,
    input  logic [axi_bridge_pkg::data_w-1:0] inst_wdata,
    input  logic                              data_req,
    input  logic                              data_wr,
    input  logic [1:0]                        data_size,
    input  logic [axi_bridge_pkg::strb_w-1:0] data_wstrb,
    input  logic [axi_bridge_pkg::addr_w-1:0] data_addr,
    input  logic [axi_bridge_pkg::data_w-1:0] data_wdata,
    input  logic                              awready,
    input  logic                              wready,
    input  logic                              bvalid,
    input  logic [axi_bridge_pkg::id_w-1:0]   bid,
    output logic [axi_bridge_pkg::id_w-1:0]   awid,
    output logic [axi_bridge_pkg::addr_w-1:0] awaddr,
    output logic [2:0]                        awsize,
    output logic                              awvalid,
    output logic [axi_bridge_pkg::id_w-1:0]   wid,
    output logic [axi_bridge_pkg::data_w-1:0] wdata,
    output logic [axi_bridge_pkg::strb_w-1:0] wstrb,
    output logic                              wvalid,
    output logic                              bready,
    output logic                              wr_busy,
    output logic [axi_bridge_pkg::addr_w-1:0] wr_addr,
    output logic                              inst_addr_ok_wr,
    output logic                              data_addr_ok_wr,
    output logic                              inst_data_ok_wr,
    output logic                              data_data_ok_wr
);
    import axi_bridge_pkg::*;

    logic [4:0] state;
    logic [4:0] state_nxt;
    logic       inst_wr_req;
    logic       data_wr_req;
    logic       aw_fire;
    logic       w_fire;
    logic       b_fire;

    assign inst_wr_req = inst_req & inst_wr;
    assign data_wr_req = data_req & data_wr;
    assign aw_fire     = awvalid & awready;
    assign w_fire      = wvalid & wready;
    assign b_fire      = bvalid & bready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= st_w_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // ******************************
    // aw and w go out together, either may land first
    always_comb begin
        state_nxt = state;
        case (state)
            st_w_idle: begin
                if (inst_wr_req | data_wr_req) begin
                    state_nxt = st_w_req;
                end
            end
            st_w_req: begin
                if (aw_fire & w_fire) begin
                    state_nxt = st_w_resp;
                end else if (aw_fire) begin
                    state_nxt = st_w_addr;
                end else if (w_fire) begin
                    state_nxt = st_w_data;
                end
            end
            st_w_addr: begin
                if (w_fire) begin
                    state_nxt = st_w_resp;
                end
            end
            st_w_data: begin
                if (aw_fire) begin
                    state_nxt = st_w_resp;
                end
            end
            st_w_resp: begin
                if (b_fire) begin
                    state_nxt = st_w_idle;
                end
            end
            default: state_nxt = st_w_idle;
        endcase
    end

    // data port first
    always_ff @(posedge aclk) begin
        if (state == st_w_idle) begin
            if (data_wr_req) begin
                awid   <= data_id;
                awaddr <= data_addr;
                awsize <= {1'b0, data_size};
                wid    <= data_id;
                wdata  <= data_wdata;
                wstrb  <= data_wstrb;
            end else if (inst_wr_req) begin
                awid   <= inst_id;
                awaddr <= inst_addr;
                awsize <= {1'b0, inst_size};
                wid    <= inst_id;
                wdata  <= inst_wdata;
                wstrb  <= inst_wstrb;
            end
        end
    end

    assign awvalid = (state == st_w_req) | (state == st_w_data);
    assign wvalid  = (state == st_w_req) | (state == st_w_addr);
    assign bready  = (state == st_w_resp);
    assign wr_busy = (state != st_w_idle);
    assign wr_addr = awaddr;

    assign inst_addr_ok_wr = w_fire & (wid == inst_id);
    assign data_addr_ok_wr = w_fire & (wid == data_id);
    assign inst_data_ok_wr = b_fire & (bid == inst_id);
    assign data_data_ok_wr = b_fire & (bid == data_id);

    // slave answers only the single write in flight
    b_expected_a: assert property (@(posedge aclk) disable iff (!aresetn)
        bvalid |-> state == st_w_resp);

endmodule

// File: logic/axi_bridge_top.sv
`timescale 1ns/1ps

module axi_bridge_top (
    input  logic                              aclk,
    input  logic                              aresetn,
    // instruction port
    input  logic                              inst_req,
    input  logic                              inst_wr,
    input  logic [1:0]                        inst_size,
    input  logic [axi_bridge_pkg::strb_w-1:0] inst_wstrb,
    input  logic [axi_bridge_pkg::addr_w-1:0] inst_addr,
    input  logic [axi_bridge_pkg::data_w-1:0] inst_wdata,
    output logic                              inst_addr_ok,
    output logic                              inst_data_ok,
    output logic [axi_bridge_pkg::data_w-1:0] inst_rdata,
    // data port
    input  logic                              data_req,
    input  logic                              data_wr,
    input  logic [1:0]                        data_size,
    input  logic [axi_bridge_pkg::strb_w-1:0] data_wstrb,
    input  logic [axi_bridge_pkg::addr_w-1:0] data_addr,
    input  logic [axi_bridge_pkg::data_w-1:0] data_wdata,
    output logic                              data_addr_ok,
    output logic                              data_data_ok,
    output logic [axi_bridge_pkg::data_w-1:0] data_rdata,
    // read address
    output logic [axi_bridge_pkg::id_w-1:0]   arid,
    output logic [axi_bridge_pkg::addr_w-1:0] araddr,
    output logic [7:0]                        arlen,
    output logic [2:0]                        arsize,
    output logic [1:0]                        arburst,
    output logic [1:0]                        arlock,
    output logic [3:0]                        arcache,
    output logic [2:0]                        arprot,
    output logic                              arvalid,
    input  logic                              arready,
    // read data
    input  logic [axi_bridge_pkg::id_w-1:0]   rid,
    input  logic [axi_bridge_pkg::data_w-1:0] rdata,
    input  logic [1:0]                        rresp,
    input  logic                              rlast,
    input  logic                              rvalid,
    output logic                              rready,
    // write address
    output logic [axi_bridge_pkg::id_w-1:0]   awid,
    output logic [axi_bridge_pkg::addr_w-1:0] awaddr,
    output logic [7:0]                        awlen,
    output logic [2:0]                        awsize,
    output logic [1:0]                        awburst,
    output logic [1:0]                        awlock,
    output logic [3:0]                        awcache,
    output logic [2:0]                        awprot,
    output logic                              awvalid,
    input  logic                              awready,
    // write data
    output logic [axi_bridge_pkg::id_w-1:0]   wid,
    output logic [axi_bridge_pkg::data_w-1:0] wdata,
    output logic [axi_bridge_pkg::strb_w-1:0] wstrb,
    output logic                              wlast,
    output logic                              wvalid,
    input  logic                              wready,
    // write response
    input  logic [axi_bridge_pkg::id_w-1:0]   bid,
    input  logic [1:0]                        bresp,
    input  logic                              bvalid,
    output logic                              bready
);
    import axi_bridge_pkg::*;

    logic              ar_fire;
    logic              rd_full;
    logic              wr_busy;
    logic [addr_w-1:0] wr_addr;
    logic              inst_addr_ok_rd;
    logic              data_addr_ok_rd;
    logic              inst_data_ok_rd;
    logic              data_data_ok_rd;
    logic              inst_addr_ok_wr;
    logic              data_addr_ok_wr;
    logic              inst_data_ok_wr;
    logic              data_data_ok_wr;

    // ******************************
    // read path
    read_request_fsm u_read_request_fsm (.*);

    read_tracker u_read_tracker (.*);

    read_return_buffer u_read_return_buffer (.*);

    // ******************************
    // write path
    write_channel_fsm u_write_channel_fsm (.*);

    // read and write pulses never overlap per port
    assign inst_addr_ok = inst_addr_ok_rd | inst_addr_ok_wr;
    assign data_addr_ok = data_addr_ok_rd | data_addr_ok_wr;
    assign inst_data_ok = inst_data_ok_rd | inst_data_ok_wr;
    assign data_data_ok = data_data_ok_rd | data_data_ok_wr;

    // single beat fields
    assign arlen   = axi_len;
    assign arburst = burst_incr;
    assign arlock  = axi_lock;
    assign arcache = axi_cache;
    assign arprot  = axi_prot;
    assign awlen   = axi_len;
    assign awburst = burst_incr;
    assign awlock  = axi_lock;
    assign awcache = axi_cache;
    assign awprot  = axi_prot;
    assign wlast   = axi_wlast;

endmodule

// File: dv/axi_slave_model.sv
`timescale 1ns/1ps

module axi_slave_model (
    input  logic                              aclk,
    input  logic                              aresetn,
    input  logic                              heavy,
    input  logic [axi_bridge_pkg::id_w-1:0]   arid,
    input  logic [axi_bridge_pkg::addr_w-1:0] araddr,
    input  logic                              arvalid,
    output logic                              arready,
    output logic [axi_bridge_pkg::id_w-1:0]   rid,
    output logic [axi_bridge_pkg::data_w-1:0] rdata,
    output logic [1:0]                        rresp,
    output logic                              rlast,
    output logic                              rvalid,
    input  logic                              rready,
    input  logic [axi_bridge_pkg::id_w-1:0]   awid,
    input  logic [axi_bridge_pkg::addr_w-1:0] awaddr,
    input  logic                              awvalid,
    output logic                              awready,
    input  logic [axi_bridge_pkg::data_w-1:0] wdata,
    input  logic [axi_bridge_pkg::strb_w-1:0] wstrb,
    input  logic                              wvalid,
    output logic                              wready,
    output logic [axi_bridge_pkg::id_w-1:0]   bid,
    output logic [1:0]                        bresp,
    output logic                              bvalid,
    input  logic                              bready
);
    import axi_bridge_pkg::*;

    logic [data_w-1:0] mem [0:255];
    logic [id_w-1:0]   rd_id_q [$];
    logic [7:0]        rd_idx_q [$];
    int                ar_wait;
    int                aw_wait;
    int                w_wait;
    int                r_wait;
    int                b_wait;
    logic              aw_got;
    logic              w_got;
    logic [7:0]        wr_idx;
    logic [id_w-1:0]   wr_id;
    logic [data_w-1:0] wr_data;
    logic [strb_w-1:0] wr_strb;
    logic [data_w-1:0] wr_mask;

    // random delay of 0 to 3 cycles
    function automatic int pick_delay();
        return $urandom % 4;
    endfunction

    // every byte of a word depends on its index
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'hc3};
        end
    end

    assign rresp   = 2'b00;
    assign rlast   = 1'b1;
    assign bresp   = 2'b00;
    assign wr_mask = {{8{wr_strb[3]}}, {8{wr_strb[2]}}, {8{wr_strb[1]}}, {8{wr_strb[0]}}};

    always @(posedge aclk) begin
        if (!aresetn) begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            ar_wait <= 0;
            aw_wait <= 0;
            w_wait  <= 0;
            r_wait  <= 0;
            b_wait  <= 0;
            rd_id_q.delete();
            rd_idx_q.delete();
        end else begin
            // ******************************
            // read address and in-order read data
            if (arvalid && arready) begin
                arready <= 1'b0;
                ar_wait <= pick_delay();
                rd_id_q.push_back(arid);
                rd_idx_q.push_back(araddr[9:2]);
            end else if (arvalid) begin
                if (ar_wait == 0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                r_wait <= pick_delay();
            end else if (!rvalid && rd_id_q.size() != 0) begin
                if (r_wait == 0) begin
                    rvalid <= 1'b1;
                    rid    <= rd_id_q.pop_front();
                    rdata  <= mem[rd_idx_q.pop_front()];
                end else begin
                    r_wait <= r_wait - 1;
                end
            end
            // ******************************
            // write address, data and response
            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_wait <= pick_delay();
                aw_got  <= 1'b1;
                wr_idx  <= awaddr[9:2];
                wr_id   <= awid;
            end else if (awvalid) begin
                if (aw_wait == 0) begin
                    awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 1;
                end
            end
            if (wvalid && wready) begin
                wready  <= 1'b0;
                w_wait  <= pick_delay();
                w_got   <= 1'b1;
                wr_data <= wdata;
                wr_strb <= wstrb;
                // heavy mode holds the write response well past a following read
                b_wait  <= heavy ? 20 : pick_delay();
            end else if (wvalid) begin
                if (w_wait == 0) begin
                    wready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end else if (aw_got && w_got && !bvalid) begin
                if (b_wait == 0) begin
                    bvalid      <= 1'b1;
                    bid         <= wr_id;
                    mem[wr_idx] <= (mem[wr_idx] & ~wr_mask) | (wr_data & wr_mask);
                end else begin
                    b_wait <= b_wait - 1;
                end
            end
        end
    end

endmodule

// File: dv/axi_bridge_tb.sv
`timescale 1ns/1ps

module axi_bridge_tb;
    import axi_bridge_pkg::*;

    logic              aclk;
    logic              aresetn;
    logic              heavy;
    logic              inst_req, inst_wr, data_req, data_wr;
    logic [1:0]        inst_size, data_size;
    logic [strb_w-1:0] inst_wstrb, data_wstrb;
    logic [addr_w-1:0] inst_addr, data_addr;
    logic [data_w-1:0] inst_wdata, data_wdata, inst_rdata, data_rdata;
    logic              inst_addr_ok, inst_data_ok, data_addr_ok, data_data_ok;
    logic [id_w-1:0]   arid, rid, awid, wid, bid;
    logic [addr_w-1:0] araddr, awaddr;
    logic [7:0]        arlen, awlen;
    logic [2:0]        arsize, awsize, arprot, awprot;
    logic [1:0]        arburst, awburst, arlock, awlock, rresp, bresp;
    logic [3:0]        arcache, awcache;
    logic              arvalid, arready, rlast, rvalid, rready;
    logic              awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic [data_w-1:0] rdata, wdata;
    logic [strb_w-1:0] wstrb;

    // reference memory and per-port requests awaiting data_ok
    // entry is {wr, strb, wdata, addr}
    logic [data_w-1:0] ref_mem [0:255];
    logic [68:0]       inst_pend [$];
    logic [68:0]       data_pend [$];
    int                errors;
    int                checks;
    int                tests_run;
    int                tests_failed;

    axi_bridge_top dut0 (.*);

    axi_slave_model mem0 (.*);

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // ******************************
    // checking helpers
    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what, input int cycles);
        errors++;
        $display("timeout at %0t: %s did not happen within %0d cycles", $time, what, cycles);
    endtask

    function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
                                                  input logic [31:0] new_word,
                                                  input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    // a write updates the model, a read is compared with it
    task automatic retire_response(input logic [68:0] entry, input logic [31:0] got,
                                   input string port);
        logic [7:0] idx;
        idx = entry[9:2];
        if (entry[68]) begin
            ref_mem[idx] = apply_strobes(ref_mem[idx], entry[63:32], entry[67:64]);
        end else begin
            check_value(got, ref_mem[idx], {port, " read data"});
        end
    endtask

    always @(posedge aclk) begin
        if (aresetn) begin
            if (inst_data_ok) begin
                if (inst_pend.size() == 0) begin
                    errors++;
                    $display("inst port gave a data_ok with nothing pending at %0t", $time);
                end else begin
                    retire_response(inst_pend.pop_front(), inst_rdata, "inst");
                end
            end
            if (data_data_ok) begin
                if (data_pend.size() == 0) begin
                    errors++;
                    $display("data port gave a data_ok with nothing pending at %0t", $time);
                end else begin
                    retire_response(data_pend.pop_front(), data_rdata, "data");
                end
            end
            // single beat word transfers, only the data port writes
            if (arvalid && arready) begin
                check_value({arlen, arsize, arburst, arlock, arcache, arprot},
                            {8'd0, 3'd2, 2'b01, 2'b00, 4'd0, 3'd0}, "ar fixed fields");
            end
            if (awvalid && awready) begin
                check_value({awid, awlen, awsize, awburst, awlock, awcache, awprot},
                            {4'd1, 8'd0, 3'd2, 2'b01, 2'b00, 4'd0, 3'd0},
                            "aw id and fixed fields");
            end
            if (wvalid && wready) begin
                check_value({wid, wlast}, {4'd1, 1'b1}, "wid and wlast");
            end
        end
    end

    // ******************************
    // stimulus
    task automatic send_request(input bit on_data, input bit wr, input logic [31:0] addr,
                                input logic [31:0] wdata_in, input logic [3:0] strb,
                                output time t_ok);
        int  n;
        bit  taken;
        @(posedge aclk);
        if (on_data) begin
            data_req   <= 1'b1;
            data_wr    <= wr;
            data_size  <= 2'd2;
            data_addr  <= addr;
            data_wdata <= wdata_in;
            data_wstrb <= strb;
        end else begin
            inst_req   <= 1'b1;
            inst_wr    <= wr;
            inst_size  <= 2'd2;
            inst_addr  <= addr;
            inst_wdata <= wdata_in;
            inst_wstrb <= strb;
        end
        taken = 1'b0;
        n = 0;
        while (!taken && n < 400) begin
            @(posedge aclk);
            taken = on_data ? data_addr_ok : inst_addr_ok;
            n++;
        end
        t_ok = $time;
        if (on_data) begin
            data_req <= 1'b0;
        end else begin
            inst_req <= 1'b0;
        end
        if (!taken) begin
            report_timeout(on_data ? "data_addr_ok" : "inst_addr_ok", 400);
        end else if (on_data) begin
            data_pend.push_back({wr, strb, wdata_in, addr});
        end else begin
            inst_pend.push_back({wr, strb, wdata_in, addr});
        end
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while ((inst_pend.size() != 0 || data_pend.size() != 0) && n < 2000) begin
            @(posedge aclk);
            n++;
        end
        if (inst_pend.size() != 0 || data_pend.size() != 0) begin
            report_timeout({"every data_ok for ", what}, 2000);
            inst_pend.delete();
            data_pend.delete();
        end
    endtask

    task automatic close_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("test %-32s failed with %0d errors", name, errors - errors_before);
        end else begin
            $display("test %-32s passed", name);
        end
    endtask

    initial begin
        int          e0;
        time         t_inst;
        time         t_data;
        logic [31:0] a;
        logic [31:0] w;
        void'($urandom(32'h8f68_763f));
        aresetn    = 1'b0;
        heavy      = 1'b0;
        inst_req   = 1'b0;
        inst_wr    = 1'b0;
        inst_size  = 2'd2;
        inst_wstrb = 4'h0;
        inst_addr  = 32'h0;
        inst_wdata = 32'h0;
        data_req   = 1'b0;
        data_wr    = 1'b0;
        data_size  = 2'd2;
        data_wstrb = 4'h0;
        data_addr  = 32'h0;
        data_wdata = 32'h0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (8) @(posedge aclk);
        aresetn <= 1'b1;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = mem0.mem[i];
        end

        e0 = errors;
        repeat (2) begin
            @(posedge aclk);
            check_value({arvalid, awvalid, wvalid, rready, bready, inst_addr_ok,
                         data_addr_ok, inst_data_ok, data_data_ok}, 32'd0,
                        "handshake outputs after reset");
        end
        close_test("reset values", e0);

        e0 = errors;
        repeat (12) begin
            a = ($urandom % 256) << 2;
            send_request(1'b0, 1'b0, a, 32'd0, 4'd0, t_inst);
            wait_drained("inst reads");
        end
        close_test("inst port reads", e0);

        e0 = errors;
        repeat (10) begin
            a = ($urandom % 256) << 2;
            w = $urandom;
            send_request(1'b1, 1'b1, a, w, 4'($urandom % 16), t_data);
            wait_drained("data write");
            send_request(1'b1, 1'b0, a, 32'd0, 4'd0, t_data);
            wait_drained("data read back");
        end
        close_test("strobed writes and read back", e0);

        // same-cycle requests, data port must win
        e0 = errors;
        repeat (6) begin
            fork
                send_request(1'b1, 1'b0, ($urandom % 256) << 2, 32'd0, 4'd0, t_data);
                send_request(1'b0, 1'b0, ($urandom % 256) << 2, 32'd0, 4'd0, t_inst);
            join
            check_value(t_data < t_inst, 32'd1, "data port accepted first");
            wait_drained("dual reads");
        end
        close_test("simultaneous reads", e0);

        e0 = errors;
        heavy <= 1'b1;
        repeat (6) begin
            a = ($urandom % 256) << 2;
            w = $urandom;
            send_request(1'b1, 1'b1, a, w, 4'hf, t_data);
            send_request(1'b1, 1'b0, a, 32'd0, 4'd0, t_data);
            wait_drained("write then read");
        end
        heavy <= 1'b0;
        close_test("read behind write", e0);

        e0 = errors;
        fork
            repeat (24) begin
                send_request(1'b1, 1'b0, ($urandom % 256) << 2, 32'd0, 4'd0, t_data);
            end
            repeat (24) begin
                send_request(1'b0, 1'b0, ($urandom % 256) << 2, 32'd0, 4'd0, t_inst);
            end
        join
        wait_drained("read burst");
        close_test("pipelined read burst", e0);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
logic/axi_bridge_pkg.sv
logic/read_request_fsm.sv
logic/read_tracker.sv
logic/read_return_buffer.sv
logic/write_channel_fsm.sv
logic/axi_bridge_top.sv
dv/axi_slave_model.sv
dv/axi_bridge_tb.sv
